// ==== design/icache_pkg.sv ====
package icache_pkg;

	// geometry of the direct-mapped cache
	localparam int FETCH_ADDR_BITS = 32;
	localparam int WORD_BITS       = 32;
	localparam int OFFSET_BITS     = 4;
	localparam int INDEX_BITS      = 4;
	localparam int TAG_BITS        = FETCH_ADDR_BITS - INDEX_BITS - OFFSET_BITS;
	localparam int LINE_WORDS      = 4;
	localparam int LINE_NUM        = 16;

	// word select inside a line, the byte offset without its low two bits
	localparam int WORD_SEL_BITS   = OFFSET_BITS - 2;

	// address layout is tag | index | offset, 24 + 4 + 4 bits
	localparam int INDEX_LSB       = OFFSET_BITS;
	localparam int TAG_LSB         = OFFSET_BITS + INDEX_BITS;

	// one fetch after the address split, 30 bits
	typedef struct packed {
		logic [TAG_BITS-1:0]      tag;
		logic [INDEX_BITS-1:0]    index;
		logic [WORD_SEL_BITS-1:0] word;
	} fetch_req_t;

	// one refill write into the data array
	typedef struct packed {
		logic                     strobe;
		logic [WORD_SEL_BITS-1:0] word;
		logic [WORD_BITS-1:0]     data;
		logic                     last;
	} refill_beat_t;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_HIT     = 2'd1,
		ST_REFILL  = 2'd2,
		ST_RESPOND = 2'd3
	} icache_state_e;

endpackage

// ==== design/axi_pkg.sv ====
package axi_pkg;

	localparam int AXI_ADDR_BITS = 32;
	localparam int AXI_DATA_BITS = 32;
	localparam int AXI_LEN_BITS  = 8;

	// arlen encodes beats minus one, so a line is four beats
	localparam logic [AXI_LEN_BITS-1:0] LINE_BURST_LEN = 8'd3;

	// read address channel, valid + addr + len = 41 bits
	typedef struct packed {
		logic                     valid;
		logic [AXI_ADDR_BITS-1:0] addr;
		logic [AXI_LEN_BITS-1:0]  len;
	} axi_ar_t;

	// read data channel without the response field, 34 bits
	typedef struct packed {
		logic                     valid;
		logic [AXI_DATA_BITS-1:0] data;
		logic                     last;
	} axi_r_t;

endpackage

// ==== design/fetch_req_port.sv ====
`timescale 1ns/1ps

module fetch_req_port import icache_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       fetch_valid_i,
	input  logic [FETCH_ADDR_BITS-1:0] fetch_addr_i,
	input  logic                       fence_i,
	input  logic                       core_idle_i,
	output logic                       req_valid_o,
	output fetch_req_t                 req_o,
	output logic                       fence_apply_o
);

	logic fence_pend_q;
	logic fence_want;

	// a fence pulse counts at once, and stays pending if the core is busy
	assign fence_want = fence_i || fence_pend_q;
	assign fence_apply_o = fence_want && core_idle_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			fence_pend_q <= 1'b0;
		end else begin
			fence_pend_q <= fence_want && !fence_apply_o;
		end
	end

	// the fence goes first, the request waits behind it
	assign req_valid_o = fetch_valid_i && !fence_want;

	// split tag | index | word
	always_comb begin
		req_o.tag   = fetch_addr_i[FETCH_ADDR_BITS-1:TAG_LSB];
		req_o.index = fetch_addr_i[TAG_LSB-1:INDEX_LSB];
		req_o.word  = fetch_addr_i[OFFSET_BITS-1:2];
	end

	// instruction fetches are always whole words
	fetch_addr_aligned: assert property (
		@(posedge clock) disable iff (reset)
		fetch_valid_i |-> (fetch_addr_i[1:0] == 2'b00)
	) else $error("fetch address %h is not word aligned", fetch_addr_i);

endmodule

// ==== design/icache_core.sv ====
`timescale 1ns/1ps

module icache_core import icache_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       req_valid_i,
	input  fetch_req_t                 req_i,
	input  logic                       fence_apply_i,
	output logic                       idle_o,
	output logic                       refill_start_o,
	output logic [FETCH_ADDR_BITS-1:0] refill_addr_o,
	input  refill_beat_t               beat_i,
	output logic                       fetch_ready_o,
	output logic [WORD_BITS-1:0]       fetch_data_o
);

	// data, tag and valid arrays
	logic [WORD_BITS-1:0] data_mem [LINE_NUM][LINE_WORDS];
	logic [TAG_BITS-1:0]  tag_mem  [LINE_NUM];
	logic [LINE_NUM-1:0]  valid_q;

	icache_state_e state_q;
	fetch_req_t    req_q;
	logic          lookup_hit;
	logic          accept;
	logic          last_beat;

	assign idle_o = (state_q == ST_IDLE);

	// hit check on the incoming request during the idle cycle
	assign lookup_hit = valid_q[req_i.index] && (tag_mem[req_i.index] == req_i.tag);

	// a fence applied in the same cycle wins over the request
	assign accept = idle_o && req_valid_i && !fence_apply_i;

	// miss starts the burst right away so the AR valid rises next cycle
	assign refill_start_o = accept && !lookup_hit;
	assign refill_addr_o  = {req_i.tag, req_i.index, {OFFSET_BITS{1'b0}}};

	assign last_beat = beat_i.strobe && beat_i.last;

	// answer comes from the array in both the hit and the respond state
	assign fetch_ready_o = (state_q == ST_HIT) || (state_q == ST_RESPOND);
	assign fetch_data_o  = data_mem[req_q.index][req_q.word];

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ST_IDLE;
			valid_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (fence_apply_i) begin
						// invalidate the whole cache in one edge
						valid_q <= '0;
					end else if (accept) begin
						state_q <= lookup_hit ? ST_HIT : ST_REFILL;
					end
				end
				ST_HIT: begin
					state_q <= ST_IDLE;
				end
				ST_REFILL: begin
					if (last_beat) begin
						valid_q[req_q.index] <= 1'b1;
						state_q <= ST_RESPOND;
					end
				end
				ST_RESPOND: begin
					state_q <= ST_IDLE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// request latch and array writes
	always_ff @(posedge clock) begin
		if (accept) begin
			req_q <= req_i;
		end
		if (beat_i.strobe) begin
			data_mem[req_q.index][beat_i.word] <= beat_i.data;
		end
		// tag is written with the last word so the line turns valid whole
		if (last_beat) begin
			tag_mem[req_q.index] <= req_q.tag;
		end
	end

	// the burst reader must only deliver while a refill is open
	beat_in_refill: assert property (
		@(posedge clock) disable iff (reset)
		beat_i.strobe |-> (state_q == ST_REFILL)
	) else $error("refill beat outside the refill state");

endmodule

// ==== design/axi_burst_reader.sv ====
`timescale 1ns/1ps

module axi_burst_reader import icache_pkg::*, axi_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     refill_start_i,
	input  logic [AXI_ADDR_BITS-1:0] refill_addr_i,
	output axi_ar_t                  axi_ar_o,
	input  logic                     axi_ar_ready_i,
	input  axi_r_t                   axi_r_i,
	output logic                     axi_r_ready_o,
	output refill_beat_t             beat_o
);

	logic                     ar_valid_q;
	logic [AXI_ADDR_BITS-1:0] ar_addr_q;
	logic                     r_busy_q;
	logic [WORD_SEL_BITS-1:0] beat_cnt_q;
	logic                     ar_fire;
	logic                     r_fire;
	logic                     cnt_at_end;
	logic                     busy;

	assign ar_fire    = ar_valid_q && axi_ar_ready_i;
	assign r_fire     = axi_r_i.valid && r_busy_q;
	assign cnt_at_end = (beat_cnt_q == LINE_BURST_LEN[WORD_SEL_BITS-1:0]);
	assign busy       = ar_valid_q || r_busy_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			ar_valid_q <= 1'b0;
			r_busy_q   <= 1'b0;
			beat_cnt_q <= '0;
		end else begin
			if (refill_start_i) begin
				ar_valid_q <= 1'b1;
			end else if (ar_fire) begin
				ar_valid_q <= 1'b0;
				r_busy_q   <= 1'b1;
				beat_cnt_q <= '0;
			end
			// counter moves on accepted beats only
			if (r_fire) begin
				beat_cnt_q <= beat_cnt_q + 1'b1;
				if (cnt_at_end) begin
					r_busy_q <= 1'b0;
				end
			end
		end
	end

	// line-aligned burst address
	always_ff @(posedge clock) begin
		if (refill_start_i) begin
			ar_addr_q <= {refill_addr_i[AXI_ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		end
	end

	always_comb begin
		axi_ar_o.valid = ar_valid_q;
		axi_ar_o.addr  = ar_addr_q;
		axi_ar_o.len   = LINE_BURST_LEN;
	end

	assign axi_r_ready_o = r_busy_q;

	// the line's end comes from the counter, AXI last is only checked
	always_comb begin
		beat_o.strobe = r_fire;
		beat_o.word   = beat_cnt_q;
		beat_o.data   = axi_r_i.data;
		beat_o.last   = r_fire && cnt_at_end;
	end

	r_last_on_fourth: assert property (
		@(posedge clock) disable iff (reset)
		r_fire |-> (axi_r_i.last == cnt_at_end)
	) else $error("AXI last flag does not match the fourth beat");

	no_start_while_busy: assert property (
		@(posedge clock) disable iff (reset)
		refill_start_i |-> !busy
	) else $error("refill start while a burst is still open");

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_pkg::*, axi_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       fetch_valid_i,
	input  logic [FETCH_ADDR_BITS-1:0] fetch_addr_i,
	input  logic                       fence_i,
	output logic                       fetch_ready_o,
	output logic [WORD_BITS-1:0]       fetch_data_o,
	output axi_ar_t                    axi_ar_o,
	input  logic                       axi_ar_ready_i,
	input  axi_r_t                     axi_r_i,
	output logic                       axi_r_ready_o
);

	logic                       req_valid;
	fetch_req_t                 req;
	logic                       fence_apply;
	logic                       core_idle;
	logic                       refill_start;
	logic [FETCH_ADDR_BITS-1:0] refill_addr;
	refill_beat_t               beat;

	// fetch side, address split and fence hold
	fetch_req_port req_port_i (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid_i (fetch_valid_i),
		.fetch_addr_i  (fetch_addr_i),
		.fence_i       (fence_i),
		.core_idle_i   (core_idle),
		.req_valid_o   (req_valid),
		.req_o         (req),
		.fence_apply_o (fence_apply)
	);

	icache_core core_i (
		.clock          (clock),
		.reset          (reset),
		.req_valid_i    (req_valid),
		.req_i          (req),
		.fence_apply_i  (fence_apply),
		.idle_o         (core_idle),
		.refill_start_o (refill_start),
		.refill_addr_o  (refill_addr),
		.beat_i         (beat),
		.fetch_ready_o  (fetch_ready_o),
		.fetch_data_o   (fetch_data_o)
	);

	// memory side, one line burst per miss
	axi_burst_reader burst_reader_i (
		.clock          (clock),
		.reset          (reset),
		.refill_start_i (refill_start),
		.refill_addr_i  (refill_addr),
		.axi_ar_o       (axi_ar_o),
		.axi_ar_ready_i (axi_ar_ready_i),
		.axi_r_i        (axi_r_i),
		.axi_r_ready_o  (axi_r_ready_o),
		.beat_o         (beat)
	);

endmodule

// ==== tests/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model import axi_pkg::*; #(
	parameter logic [31:0] DATA_XOR = 32'h0
) (
	input  logic                     clock,
	input  logic                     reset,
	input  axi_ar_t                  ar_i,
	output logic                     ar_ready_o,
	output axi_r_t                   r_o,
	input  logic                     r_ready_i,
	output int                       burst_cnt_o,
	output logic [AXI_ADDR_BITS-1:0] burst_addr_o,
	output logic [AXI_LEN_BITS-1:0]  burst_len_o
);

	logic [31:0] lfsr_q = 32'd92126;
	logic        in_data_q;
	logic [1:0]  beat_q;
	logic [1:0]  delay_q;

	// galois lfsr, one step per bit
	function automatic logic [1:0] rand_wait();
		logic [1:0] bits;
		for (int i = 0; i < 2; i++) begin
			bits[i] = lfsr_q[0];
			lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'hB4BC_D35C : 32'h0);
		end
		return bits;
	endfunction

	initial begin
		ar_ready_o = 1'b0;
		r_o = '0;
	end

	always @(posedge clock) begin
		if (reset) begin
			ar_ready_o <= 1'b0;
			r_o <= '0;
			in_data_q <= 1'b0;
			beat_q <= '0;
			delay_q <= '0;
			burst_cnt_o <= 0;
			burst_addr_o <= '0;
			burst_len_o <= '0;
		end else if (!in_data_q) begin
			if (ar_ready_o && ar_i.valid) begin
				// address handshake, record the burst
				ar_ready_o <= 1'b0;
				burst_cnt_o <= burst_cnt_o + 1;
				burst_addr_o <= ar_i.addr;
				burst_len_o <= ar_i.len;
				in_data_q <= 1'b1;
				beat_q <= '0;
				delay_q <= rand_wait();
			end else if (ar_i.valid) begin
				if (delay_q == 2'd0) begin
					ar_ready_o <= 1'b1;
				end else begin
					delay_q <= delay_q - 1'b1;
				end
			end
		end else if (r_o.valid && r_ready_i) begin
			r_o.valid <= 1'b0;
			beat_q <= beat_q + 1'b1;
			delay_q <= rand_wait();
			if (beat_q == 2'd3) begin
				in_data_q <= 1'b0;
			end
		end else if (!r_o.valid) begin
			if (delay_q == 2'd0) begin
				// data is the word address xor a constant
				r_o.valid <= 1'b1;
				r_o.data <= ((burst_addr_o >> 2) + beat_q) ^ DATA_XOR;
				r_o.last <= (beat_q == 2'd3);
			end else begin
				delay_q <= delay_q - 1'b1;
			end
		end
	end

endmodule

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb import icache_pkg::*, axi_pkg::*; ();

	localparam logic [31:0] DATA_XOR = 32'h5A5A_C3C3;
	localparam int TIMEOUT = 200;

	logic                 clock;
	logic                 reset;
	logic                 fetch_valid_i;
	logic [31:0]          fetch_addr_i;
	logic                 fence_i;
	logic                 fetch_ready_o;
	logic [31:0]          fetch_data_o;
	axi_ar_t              axi_ar_o;
	logic                 axi_ar_ready_i;
	axi_r_t               axi_r_i;
	logic                 axi_r_ready_o;
	int                   burst_cnt;
	logic [31:0]          burst_addr;
	logic [7:0]           burst_len;
	logic [31:0]          lfsr = 32'd92126;
	// reference tag and valid arrays that mirror the cache contents
	logic [TAG_BITS-1:0]  ref_tag [LINE_NUM];
	logic [LINE_NUM-1:0]  ref_valid;

	icache_top dut_i (.*);

	axi_mem_model #(.DATA_XOR(DATA_XOR)) mem_model_i (
		.clock        (clock),
		.reset        (reset),
		.ar_i         (axi_ar_o),
		.ar_ready_o   (axi_ar_ready_i),
		.r_o          (axi_r_i),
		.r_ready_i    (axi_r_ready_o),
		.burst_cnt_o  (burst_cnt),
		.burst_addr_o (burst_addr),
		.burst_len_o  (burst_len)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits = '0;
		for (int i = 0; i < n; i++) begin
			bits[i] = lfsr[0];
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hB4BC_D35C : 32'h0);
		end
		return bits;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("error at %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// one fetch with an optional fence pulse while the refill runs
	task automatic fetch_check(input logic [31:0] addr, input bit fence_mid);
		fetch_req_t req = addr[31:2];
		int         burst_before = burst_cnt;
		int         cycles = 0;
		bit         hit;
		bit         done = 0;
		bit         fence_due = 0;
		bit         fenced = 0;
		hit = ref_valid[req.index] && (ref_tag[req.index] == req.tag);
		@(posedge clock);
		fetch_valid_i <= 1'b1;
		fetch_addr_i <= addr;
		while (!done) begin
			@(negedge clock);
			cycles++;
			done = fetch_ready_o;
			fence_due = fence_mid && !fenced && axi_r_ready_o;
			fenced |= fence_due;
			if (!done && cycles > TIMEOUT) begin
				stop_run($sformatf("fetch of %h got no ready within %0d cycles",
					addr, TIMEOUT));
			end
			if (!done) begin
				@(posedge clock);
				fence_i <= fence_due;
			end
		end
		check_equal("fetch_data_o", fetch_data_o, (addr >> 2) ^ DATA_XOR);
		check_equal("burst count", burst_cnt, burst_before + (hit ? 0 : 1));
		if (hit) begin
			// accepted at the first edge and ready in the cycle after
			check_equal("hit latency", cycles, 2);
		end else begin
			check_equal("axi_ar_o.addr", burst_addr, {addr[31:4], 4'h0});
			check_equal("axi_ar_o.len", burst_len, LINE_BURST_LEN);
		end
		@(posedge clock);
		fetch_valid_i <= 1'b0;
		fence_i <= 1'b0;
		// ready is a single-cycle pulse
		@(negedge clock);
		check_equal("fetch_ready_o", fetch_ready_o, 0);
		ref_valid[req.index] = 1'b1;
		ref_tag[req.index] = req.tag;
		if (fenced) begin
			ref_valid = '0;
		end
	endtask

	task automatic fence_idle();
		@(posedge clock);
		fence_i <= 1'b1;
		@(posedge clock);
		fence_i <= 1'b0;
		ref_valid = '0;
	endtask

	initial begin
		reset = 1'b1;
		fetch_valid_i = 1'b0;
		fetch_addr_i = '0;
		fence_i = 1'b0;
		ref_valid = '0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_equal("fetch_ready_o", fetch_ready_o, 0);
		check_equal("axi_ar_o.valid", axi_ar_o.valid, 0);
		check_equal("axi_r_ready_o", axi_r_ready_o, 0);
		// cold miss and then hits on the rest of the line
		fetch_check(32'h0000_0108, 0);
		fetch_check(32'h0000_0100, 0);
		fetch_check(32'h0000_0104, 0);
		fetch_check(32'h0000_010C, 0);
		// two tags on the same index evict each other
		for (int i = 0; i < 3; i++) begin
			fetch_check(32'h0000_1040, 0);
			fetch_check(32'h0000_2044, 0);
		end
		fetch_check(32'h0000_3000, 0);
		fetch_check(32'h0000_3004, 0);
		fence_idle();
		fetch_check(32'h0000_3004, 0);
		// fence during refill is held until idle
		fetch_check(32'h0000_5010, 1);
		fetch_check(32'h0000_5014, 0);
		repeat (60) begin
			fetch_check(32'h0000_8000 + (rand_bits(8) << 2), 0);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== sim.f ====
design/icache_pkg.sv
design/axi_pkg.sv
design/fetch_req_port.sv
design/icache_core.sv
design/axi_burst_reader.sv
design/icache_top.sv
tests/axi_mem_model.sv
tests/icache_tb.sv
